//--- dccm_tlul.f
logic/dccm_pkg.sv
logic/dccm_tl_adapter.sv
logic/dccm_sram.sv
logic/dccm_rsp_fifo.sv
logic/dccm_tlul.sv
dv/dccm_tlul_tb.sv

//--- dv/dccm_tlul_tb.sv
// ##########################################################################
// dccm testbench
// random TL-UL traffic against a reference memory, in-order response
// tracking, D-channel stall stability and full-rate throughput checks
// ##########################################################################

`timescale 1ns/1ps

module dccm_tlul_tb;

    import dccm_pkg::*;

    localparam int NUM_TXN   = 1500;
    localparam int NUM_WORDS = 64;     // half at the bottom, half at the top
    localparam int BURST_LEN = 32;
    localparam int TIMEOUT   = 20000;  // ~13 cycles per transaction

    typedef struct packed {
        logic [2:0]        opcode;
        logic [TL_SZW-1:0] size;
        logic [TL_IW-1:0]  source;
        logic              error;
        logic [TL_DW-1:0]  data;
        logic              burst;  // issued with d_ready held high
        logic [31:0]       cycle;  // acceptance cycle
    } rsp_t;

    logic              clk_i;
    logic              rst_ni;
    logic              a_valid_i;
    logic [2:0]        a_opcode_i;
    logic [TL_SZW-1:0] a_size_i;
    logic [TL_IW-1:0]  a_source_i;
    logic [TL_AW-1:0]  a_address_i;
    logic [TL_MW-1:0]  a_mask_i;
    logic [TL_DW-1:0]  a_data_i;
    logic              a_ready_o;
    logic              d_valid_o;
    logic [2:0]        d_opcode_o;
    logic [TL_SZW-1:0] d_size_o;
    logic [TL_IW-1:0]  d_source_o;
    logic [TL_DW-1:0]  d_data_o;
    logic              d_error_o;
    logic              d_ready_i;

    integer           seed      = 32'hf4a02b9d;
    int               errors    = 0;
    int               checks    = 0;
    int unsigned      cycle_cnt = 0;
    logic             burst_on  = 1'b0;
    logic [TL_DW-1:0] model [MEM_DEPTH];  // reference copy of the words in use
    rsp_t             exp_q [$];          // expected responses, oldest first

    dccm_tlul i_dccm_tlul (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // first cycle out of reset
    assert property (@(posedge clk_i) $rose(rst_ni) |-> (!d_valid_o && a_ready_o))
        else begin
            errors++;
            $display("D valid set or A ready clear in the first cycle after reset");
        end

    // a stalled response holds every field
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (d_valid_o && !d_ready_i) |=> (d_valid_o && $stable(d_opcode_o) && $stable(d_size_o)
            && $stable(d_source_o) && $stable(d_data_o) && $stable(d_error_o)))
        else begin
            errors++;
            $display("D channel changed while stalled, cycle %0d", cycle_cnt);
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) burst_on |-> a_ready_o)
        else begin
            errors++;
            $display("A ready dropped during the full-rate burst, cycle %0d", cycle_cnt);
        end

    function automatic int pick(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // word index of the k-th word in use
    function automatic logic [MEM_AW-1:0] touched_word(input int k);
        if (k < NUM_WORDS / 2) begin
            return MEM_AW'(k);
        end
        return MEM_AW'(MEM_DEPTH - NUM_WORDS + k);
    endfunction

    // response the bus rules call for, from the request on the A channel
    function automatic rsp_t expect_response();
        rsp_t r;
        logic op_ok;
        op_ok = (a_opcode_i == OP_PUT_FULL) || (a_opcode_i == OP_PUT_PARTIAL) ||
                (a_opcode_i == OP_GET);
        r        = '0;
        r.error  = !op_ok || (a_size_i != 2'd2) || (a_address_i[1:0] != 2'b00) ||
                   (a_address_i[TL_AW-1:MEM_AW+2] != '0) ||
                   ((a_opcode_i == OP_PUT_FULL) && (a_mask_i != 4'hf));
        r.opcode = (a_opcode_i == OP_GET) ? OP_ACK_DATA : OP_ACK;
        r.size   = a_size_i;    // echoed
        r.source = a_source_i;  // echoed
        if (!r.error && (a_opcode_i == OP_GET)) begin
            r.data = model[a_address_i[MEM_AW+1:2]];
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic check_response();
        rsp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("response on the D channel with nothing outstanding, cycle %0d", cycle_cnt);
            return;
        end
        e = exp_q.pop_front();
        check_field("d_opcode_o", 32'(e.opcode), 32'(d_opcode_o));
        check_field("d_size_o", 32'(e.size), 32'(d_size_o));
        check_field("d_source_o", 32'(e.source), 32'(d_source_o));
        check_field("d_error_o", 32'(e.error), 32'(d_error_o));
        check_field("d_data_o", e.data, d_data_o);
        if (e.burst) begin
            assert (cycle_cnt - e.cycle == 1) else begin
                errors++;
                $display("burst response came %0d cycles after acceptance", cycle_cnt - e.cycle);
            end
        end
    endtask

    // writes land in the model at acceptance, as in the memory
    task automatic record_request();
        rsp_t              e;
        logic [MEM_AW-1:0] w;
        e = expect_response();
        w = a_address_i[MEM_AW+1:2];
        if (!e.error && (a_opcode_i != OP_GET)) begin
            for (int b = 0; b < TL_MW; b++) begin
                if (a_mask_i[b]) model[w][b*8 +: 8] = a_data_i[b*8 +: 8];
            end
        end
        e.burst = burst_on;
        e.cycle = cycle_cnt;
        exp_q.push_back(e);
    endtask

    task automatic drive_d_ready();
        d_ready_i = burst_on ? 1'b1 : (pick(100) < 70);  // 70% ready
    endtask

    task automatic preload_word(input int k);
        a_opcode_i  = OP_PUT_FULL;
        a_size_i    = SIZE_WORD;
        a_source_i  = TL_IW'(k);
        a_address_i = {{(TL_AW-MEM_AW-2){1'b0}}, touched_word(k), 2'b00};
        a_mask_i    = '1;
        a_data_i    = $random(seed);
    endtask

    // 30% get, 25% full put, 25% partial put, 20% illegal
    task automatic make_request(input bit legal_only);
        int kind;
        int sub;
        kind = pick(legal_only ? 80 : 100);
        sub  = pick(5);
        a_opcode_i  = OP_GET;
        a_size_i    = SIZE_WORD;
        a_source_i  = TL_IW'($random(seed));
        a_address_i = {{(TL_AW-MEM_AW-2){1'b0}}, touched_word(pick(NUM_WORDS)), 2'b00};
        a_mask_i    = '1;
        a_data_i    = $random(seed);
        if (kind >= 30 && kind < 55) begin
            a_opcode_i = OP_PUT_FULL;
        end else if (kind >= 55 && kind < 80) begin
            a_opcode_i = OP_PUT_PARTIAL;
            a_mask_i   = TL_MW'($random(seed));  // no lane at all is legal too
        end else if (kind >= 80) begin
            a_opcode_i = (pick(2) != 0) ? OP_PUT_PARTIAL : OP_GET;
            case (sub)
                0: a_address_i[1:0] = 2'(1 + pick(3));  // misaligned
                1: a_address_i[MEM_AW + 2 + pick(TL_AW - MEM_AW - 2)] = 1'b1;  // past 8 KiB
                2: begin
                    a_opcode_i = 3'(pick(5) + 2);
                    if (a_opcode_i == OP_GET) a_opcode_i = 3'd7;
                end
                3: begin
                    a_size_i = 2'(pick(3));
                    if (a_size_i == SIZE_WORD) a_size_i = 2'd3;
                end
                default: begin
                    a_opcode_i = OP_PUT_FULL;
                    a_mask_i   = TL_MW'(pick(15));  // never all lanes
                end
            endcase
        end
    endtask

    // hold the request until the DUT takes it
    task automatic send_request();
        logic taken;
        taken     = 1'b0;
        a_valid_i = 1'b1;
        while (!taken) begin
            @(posedge clk_i);
            taken = a_ready_o;
            @(negedge clk_i);
            drive_d_ready();
        end
        a_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            drive_d_ready();
        end
    endtask

    // D side first, its entry is the older one
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (rst_ni) begin
            if (d_valid_o && d_ready_i) check_response();
            if (a_valid_i && a_ready_o) record_request();
            assert (exp_q.size() <= RSP_DEPTH) else begin
                errors++;
                $display("more than %0d requests outstanding, cycle %0d", RSP_DEPTH, cycle_cnt);
            end
        end
    end

    initial begin
        @(negedge clk_i);
        while (cycle_cnt < TIMEOUT) @(negedge clk_i);
        $display("timeout after %0d cycles with %0d responses outstanding",
                 TIMEOUT, exp_q.size());
        $display("checks %0d errors %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_ni      = 1'b0;
        a_valid_i   = 1'b0;
        a_opcode_i  = OP_GET;
        a_size_i    = SIZE_WORD;
        a_source_i  = '0;
        a_address_i = '0;
        a_mask_i    = '0;
        a_data_i    = '0;
        d_ready_i   = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // memory powers up unknown, give each word in use a value
        for (int k = 0; k < NUM_WORDS; k++) begin
            preload_word(k);
            send_request();
        end
        for (int n = 0; n < NUM_TXN; n++) begin
            if (pick(5) == 0) begin
                @(negedge clk_i);  // idle gap
                drive_d_ready();
            end
            make_request(1'b0);
            send_request();
        end
        drain();
        burst_on  = 1'b1;  // queue empty here
        d_ready_i = 1'b1;
        for (int n = 0; n < BURST_LEN; n++) begin
            make_request(1'b1);
            send_request();
        end
        drain();
        burst_on = 1'b0;
        repeat (4) @(negedge clk_i);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- logic/dccm_pkg.sv
// ##########################################################################
// dccm package
// shared widths, TL-UL opcodes, memory depth and outstanding limit
// for the data memory behind the device port
// ##########################################################################

package dccm_pkg;

    // TL-UL bus field widths
    localparam int TL_AW  = 32;  // byte address
    localparam int TL_DW  = 32;  // data bus
    localparam int TL_MW  = 4;   // byte mask, one bit per lane
    localparam int TL_SZW = 2;   // log2 of access size
    localparam int TL_IW  = 8;   // source id

    // storage geometry
    localparam int MEM_DEPTH = 2048;  // words
    localparam int MEM_AW    = 11;    // word address bits

    // word size code, only legal size
    localparam logic [TL_SZW-1:0] SIZE_WORD = 2'd2;

    // outstanding limit, equal to response queue depth
    localparam int RSP_DEPTH = 2;
    localparam int RSP_CW    = 2;  // holds 0..RSP_DEPTH

    // A channel opcodes
    localparam logic [2:0] OP_PUT_FULL    = 3'd0;
    localparam logic [2:0] OP_PUT_PARTIAL = 3'd1;
    localparam logic [2:0] OP_GET         = 3'd4;

    // D channel opcodes
    localparam logic [2:0] OP_ACK      = 3'd0;
    localparam logic [2:0] OP_ACK_DATA = 3'd1;

    // address bits above the 8 KiB window must be zero
    localparam int ADDR_TOP_LSB = MEM_AW + 2;

endpackage

//--- logic/dccm_rsp_fifo.sv
// ##########################################################################
// dccm response queue
// two-entry in-order queue that drives the D channel, with bypass
// of an incoming response when empty
// ##########################################################################

`timescale 1ns/1ps

module dccm_rsp_fifo (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // from the adapter
    input  logic                        push_i,
    input  logic [2:0]                  opcode_i,  // request opcode
    input  logic [dccm_pkg::TL_SZW-1:0] size_i,
    input  logic [dccm_pkg::TL_IW-1:0]  source_i,
    input  logic                        error_i,
    input  logic [dccm_pkg::TL_DW-1:0]  data_i,
    output logic [dccm_pkg::RSP_CW-1:0] count_o,

    // D channel
    output logic                        d_valid_o,
    output logic [2:0]                  d_opcode_o,
    output logic [dccm_pkg::TL_SZW-1:0] d_size_o,
    output logic [dccm_pkg::TL_IW-1:0]  d_source_o,
    output logic [dccm_pkg::TL_DW-1:0]  d_data_o,
    output logic                        d_error_o,
    input  logic                        d_ready_i
);

    import dccm_pkg::*;

    // entry storage
    logic [2:0]        op_q   [RSP_DEPTH];
    logic [TL_SZW-1:0] size_q [RSP_DEPTH];
    logic [TL_IW-1:0]  src_q  [RSP_DEPTH];
    logic              err_q  [RSP_DEPTH];
    logic [TL_DW-1:0]  data_q [RSP_DEPTH];

    logic              wptr_q;  // one bit wraps at depth 2
    logic              rptr_q;
    logic [RSP_CW-1:0] count_q;

    logic              empty;
    logic              pop;
    logic              wr_en;
    logic              rd_en;
    logic [2:0]        d_op_in;

    // get answers with data, puts and bad opcodes with a plain ack
    assign d_op_in = (opcode_i == OP_GET) ? OP_ACK_DATA : OP_ACK;

    assign empty = (count_q == '0);
    assign pop   = d_valid_o & d_ready_i;
    assign wr_en = push_i & ~(empty & d_ready_i);  // bypassed entry never stored
    assign rd_en = pop & ~empty;

    // head entry or the incoming response when nothing is queued
    assign d_valid_o  = ~empty | push_i;
    assign d_opcode_o = empty ? d_op_in  : op_q[rptr_q];
    assign d_size_o   = empty ? size_i   : size_q[rptr_q];
    assign d_source_o = empty ? source_i : src_q[rptr_q];
    assign d_error_o  = empty ? error_i  : err_q[rptr_q];
    assign d_data_o   = empty ? data_i   : data_q[rptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            op_q[wptr_q]   <= d_op_in;
            size_q[wptr_q] <= size_i;
            src_q[wptr_q]  <= source_i;
            err_q[wptr_q]  <= error_i;
            data_q[wptr_q] <= data_i;
        end
    end

    // pointers and count
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wptr_q  <= 1'b0;
            rptr_q  <= 1'b0;
            count_q <= '0;
        end else begin
            if (wr_en) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (rd_en) begin
                rptr_q <= rptr_q + 1'b1;
            end
            count_q <= count_q + RSP_CW'(wr_en) - RSP_CW'(rd_en);  // push and pop may overlap
        end
    end

    assign count_o = count_q;

endmodule

//--- logic/dccm_sram.sv
// ##########################################################################
// dccm sram
// 2048 x 32 word storage, bit-wise write merge under mask,
// read data registered with a valid strobe one cycle later
// ##########################################################################

`timescale 1ns/1ps

module dccm_sram (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [dccm_pkg::MEM_AW-1:0] addr_i,
    input  logic [dccm_pkg::TL_DW-1:0]  wdata_i,
    input  logic [dccm_pkg::TL_DW-1:0]  wmask_i,
    output logic [dccm_pkg::TL_DW-1:0]  rdata_o,
    output logic                        rvalid_o
);

    import dccm_pkg::*;

    logic [TL_DW-1:0] mem_q [MEM_DEPTH];  // contents survive reset
    logic [TL_DW-1:0] rdata_q;
    logic             rvalid_q;

    // write port, unmasked bits keep the old value
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
        end
    end

    // read port
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    // valid strobe for reads only
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else if (we_i) begin
            rvalid_q <= 1'b0;  // write cycle returns nothing
        end else begin
            rvalid_q <= req_i;
        end
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

endmodule

//--- logic/dccm_tl_adapter.sv
// ##########################################################################
// dccm TL-UL adapter
// decodes the A channel, flags illegal requests, issues one memory cycle
// per legal request and holds the response for one cycle before the push
// ##########################################################################

`timescale 1ns/1ps

module dccm_tl_adapter (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // A channel
    input  logic                        a_valid_i,
    input  logic [2:0]                  a_opcode_i,
    input  logic [dccm_pkg::TL_SZW-1:0] a_size_i,
    input  logic [dccm_pkg::TL_IW-1:0]  a_source_i,
    input  logic [dccm_pkg::TL_AW-1:0]  a_address_i,
    input  logic [dccm_pkg::TL_MW-1:0]  a_mask_i,
    input  logic [dccm_pkg::TL_DW-1:0]  a_data_i,
    output logic                        a_ready_o,

    // memory port
    output logic                        mem_req_o,
    output logic                        mem_we_o,
    output logic [dccm_pkg::MEM_AW-1:0] mem_addr_o,
    output logic [dccm_pkg::TL_DW-1:0]  mem_wdata_o,
    output logic [dccm_pkg::TL_DW-1:0]  mem_wmask_o,
    input  logic [dccm_pkg::TL_DW-1:0]  mem_rdata_i,
    input  logic                        mem_rvalid_i,

    // response queue
    output logic                        rsp_push_o,
    output logic [2:0]                  rsp_opcode_o,
    output logic [dccm_pkg::TL_SZW-1:0] rsp_size_o,
    output logic [dccm_pkg::TL_IW-1:0]  rsp_source_o,
    output logic                        rsp_error_o,
    output logic [dccm_pkg::TL_DW-1:0]  rsp_data_o,
    input  logic [dccm_pkg::RSP_CW-1:0] rsp_count_i
);

    import dccm_pkg::*;

    logic              pending_q;      // response waiting one cycle
    logic [2:0]        pend_opcode_q;  // request opcode, translated later
    logic [TL_SZW-1:0] pend_size_q;
    logic [TL_IW-1:0]  pend_source_q;
    logic              pend_error_q;

    logic [RSP_CW:0]   inflight;  // pending plus queued
    logic              accept;
    logic              op_ok;
    logic              req_err;

    // one extra bit so pending + full queue cannot wrap
    assign inflight  = {{RSP_CW{1'b0}}, pending_q} + {1'b0, rsp_count_i};
    assign a_ready_o = (inflight < RSP_DEPTH);
    assign accept    = a_valid_i & a_ready_o;

    // error rule
    assign op_ok = (a_opcode_i == OP_PUT_FULL) ||
                   (a_opcode_i == OP_PUT_PARTIAL) ||
                   (a_opcode_i == OP_GET);

    always_comb begin
        req_err = 1'b0;
        if (!op_ok) begin
            req_err = 1'b1;  // unsupported opcode
        end
        if (a_size_i != SIZE_WORD) begin
            req_err = 1'b1;  // word accesses only
        end
        if (a_address_i[1:0] != 2'b00) begin
            req_err = 1'b1;  // misaligned
        end
        if (a_address_i[TL_AW-1:ADDR_TOP_LSB] != '0) begin
            req_err = 1'b1;  // outside the 8 KiB window
        end
        // a full put must carry every byte lane
        if ((a_opcode_i == OP_PUT_FULL) && (a_mask_i != {TL_MW{1'b1}})) begin
            req_err = 1'b1;
        end
    end

    // memory cycle for legal requests only
    assign mem_req_o   = accept & ~req_err;
    assign mem_we_o    = (a_opcode_i != OP_GET);  // either put writes
    assign mem_addr_o  = a_address_i[ADDR_TOP_LSB-1:2];  // word index
    assign mem_wdata_o = a_data_i;

    // byte mask to bit mask
    always_comb begin
        for (int b = 0; b < TL_MW; b++) begin
            mem_wmask_o[b*8 +: 8] = {8{a_mask_i[b]}};
        end
    end

    // pending flag
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= accept;  // push follows accept by one cycle
        end
    end

    // response fields captured at accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pend_opcode_q <= a_opcode_i;
            pend_size_q   <= a_size_i;    // echoed back
            pend_source_q <= a_source_i;  // echoed back
            pend_error_q  <= req_err;
        end
    end

    // push the held response
    assign rsp_push_o   = pending_q;
    assign rsp_opcode_o = pend_opcode_q;
    assign rsp_size_o   = pend_size_q;
    assign rsp_source_o = pend_source_q;
    assign rsp_error_o  = pend_error_q;
    // read data lines up with the pending cycle and is zero for puts and errors
    assign rsp_data_o   = mem_rvalid_i ? mem_rdata_i : '0;

endmodule

//--- logic/dccm_tlul.sv
// ##########################################################################
// dccm top level
// TL-UL device port in front of a 2048 x 32 data memory,
// adapter, storage and response queue wired together
// ##########################################################################

`timescale 1ns/1ps

module dccm_tlul (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // A channel
    input  logic                        a_valid_i,
    input  logic [2:0]                  a_opcode_i,
    input  logic [dccm_pkg::TL_SZW-1:0] a_size_i,
    input  logic [dccm_pkg::TL_IW-1:0]  a_source_i,
    input  logic [dccm_pkg::TL_AW-1:0]  a_address_i,
    input  logic [dccm_pkg::TL_MW-1:0]  a_mask_i,
    input  logic [dccm_pkg::TL_DW-1:0]  a_data_i,
    output logic                        a_ready_o,

    // D channel
    output logic                        d_valid_o,
    output logic [2:0]                  d_opcode_o,
    output logic [dccm_pkg::TL_SZW-1:0] d_size_o,
    output logic [dccm_pkg::TL_IW-1:0]  d_source_o,
    output logic [dccm_pkg::TL_DW-1:0]  d_data_o,
    output logic                        d_error_o,
    input  logic                        d_ready_i
);

    import dccm_pkg::*;

    // adapter to memory
    logic              mem_req;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [TL_DW-1:0]  mem_wdata;
    logic [TL_DW-1:0]  mem_wmask;
    logic [TL_DW-1:0]  mem_rdata;
    logic              mem_rvalid;

    // adapter to response queue
    logic              rsp_push;
    logic [2:0]        rsp_opcode;
    logic [TL_SZW-1:0] rsp_size;
    logic [TL_IW-1:0]  rsp_source;
    logic              rsp_error;
    logic [TL_DW-1:0]  rsp_data;
    logic [RSP_CW-1:0] rsp_count;

    dccm_tl_adapter i_adapter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .a_valid_i    (a_valid_i),
        .a_opcode_i   (a_opcode_i),
        .a_size_i     (a_size_i),
        .a_source_i   (a_source_i),
        .a_address_i  (a_address_i),
        .a_mask_i     (a_mask_i),
        .a_data_i     (a_data_i),
        .a_ready_o    (a_ready_o),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_wmask_o  (mem_wmask),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (mem_rvalid),
        .rsp_push_o   (rsp_push),
        .rsp_opcode_o (rsp_opcode),
        .rsp_size_o   (rsp_size),
        .rsp_source_o (rsp_source),
        .rsp_error_o  (rsp_error),
        .rsp_data_o   (rsp_data),
        .rsp_count_i  (rsp_count)
    );

    // always granted, one cycle read
    dccm_sram i_sram (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (mem_req),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .wmask_i  (mem_wmask),
        .rdata_o  (mem_rdata),
        .rvalid_o (mem_rvalid)
    );

    dccm_rsp_fifo i_rsp_fifo (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .push_i     (rsp_push),
        .opcode_i   (rsp_opcode),
        .size_i     (rsp_size),
        .source_i   (rsp_source),
        .error_i    (rsp_error),
        .data_i     (rsp_data),
        .count_o    (rsp_count),
        .d_valid_o  (d_valid_o),
        .d_opcode_o (d_opcode_o),
        .d_size_o   (d_size_o),
        .d_source_o (d_source_o),
        .d_data_o   (d_data_o),
        .d_error_o  (d_error_o),
        .d_ready_i  (d_ready_i)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the DCCM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=build

verilator --binary --timing --assert -Wno-fatal \
    --top-module dccm_tlul_tb --Mdir "$BUILD" -o dccm_sim \
    -f dccm_tlul.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD/dccm_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
